/* list.f */
+incdir+logic
logic/fifo_ctrl_pkg.sv
logic/fifo_req_decode.sv
logic/fifo_ptr_execute.sv
logic/fifo_flag_result.sv
logic/fifo_ctrl_top.sv
dv/fifo_ctrl_tb.sv

/* Makefile */
# Verilator build and run for the FIFO controller testbench
# override any variable on the command line, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= fifo_ctrl_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)
PASS_MSG  ?= TESTS PASSED

SOURCES := $(shell sed -n '/\.s\?v$$/p' $(FILELIST)) logic/fifo_ctrl_cfg.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# pass only when the pass line shows up in the output
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* dv/fifo_ctrl_tb.sv */
// random traffic in three phases against a cycle model of the controller
// expects the stop-on-full and stop-on-empty rules with fixed thresholds
`include "fifo_ctrl_cfg.svh"

module fifo_ctrl_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import fifo_ctrl_pkg::*;

   localparam int RESET_CYCLES   = 8;
   localparam int PHASE_CYCLES   = 600;
   // three phases plus reset and margin
   localparam int TIMEOUT_CYCLES = 3 * PHASE_CYCLES + 200;
   localparam int PH_WRITE = 0;
   localparam int PH_READ  = 1;
   localparam int PH_BAL   = 2;

   logic   pos_clk = 1'b0;
   logic   aresetn = 1'b0;
   logic   we_i = 1'b0;
   logic   re_i = 1'b0;
   addr_t  mem_waddr, mem_raddr;
   logic   mem_we, mem_re;
   level_t level;
   logic   full, afull, empty, aempty;
   logic   wack, dvld, overflow, underflow;

   // model state as the registers should hold it
   int     m_level = 0;
   addr_t  m_waddr = '0;
   addr_t  m_raddr = '0;
   logic   m_full = 1'b0, m_afull = 1'b0, m_empty = 1'b1, m_aempty = 1'b1;
   logic   m_wack = 1'b0, m_dvld = 1'b0, m_ovf = 1'b0, m_unf = 1'b0;

   integer seed = 30;
   int     cycle_cnt = 0;
   int     level_errs = 0, addr_errs = 0, flag_errs = 0, other_errs = 0;
   // event counts for the closing sanity checks
   int     n_ovf = 0, n_unf = 0, n_both = 0, n_wrap = 0;

   always #2 pos_clk = ~pos_clk;

   fifo_ctrl_top dut0 (
      .pos_clk (pos_clk), .aresetn (aresetn), .we_i (we_i), .re_i (re_i),
      .mem_waddr_o (mem_waddr), .mem_raddr_o (mem_raddr),
      .mem_we_o (mem_we), .mem_re_o (mem_re), .level_o (level),
      .full_o (full), .afull_o (afull), .empty_o (empty), .aempty_o (aempty),
      .wack_o (wack), .dvld_o (dvld), .overflow_o (overflow), .underflow_o (underflow)
   );

   // --------------------
   // compare tasks
   // --------------------
   task automatic check_level(input string name, input level_t exp, input level_t act);
      if (act !== exp) begin
         level_errs++;
         $display("error %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic check_addr(input string name, input addr_t exp, input addr_t act);
      if (act !== exp) begin
         addr_errs++;
         $display("error %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         flag_errs++;
         $display("error %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   // registered outputs are stable since the last rising edge
   task automatic check_registered(input string name);
      check_level({name, " level"}, level_t'(m_level), level);
      check_addr({name, " waddr"}, m_waddr, mem_waddr);
      check_addr({name, " raddr"}, m_raddr, mem_raddr);
      check_flag({name, " full"}, m_full, full);
      check_flag({name, " afull"}, m_afull, afull);
      check_flag({name, " empty"}, m_empty, empty);
      check_flag({name, " aempty"}, m_aempty, aempty);
      check_flag({name, " wack"}, m_wack, wack);
      check_flag({name, " dvld"}, m_dvld, dvld);
      check_flag({name, " overflow"}, m_ovf, overflow);
      check_flag({name, " underflow"}, m_unf, underflow);
   endtask

   // --------------------
   // one cycle of traffic
   // --------------------
   task automatic run_cycle(input int phase, input string name);
      logic [31:0] r;
      logic we;
      logic re;
      logic wr_acc;
      logic rd_acc;
      @(negedge pos_clk);
      check_registered(name);
      r = $random(seed);
      // write-heavy has 7/8 writes and 1/4 reads
      // read-heavy mirrors it
      case (phase)
         PH_WRITE: begin
            we = (r[2:0] != 3'd0);
            re = (r[5:4] == 2'd0);
         end
         PH_READ: begin
            we = (r[5:4] == 2'd0);
            re = (r[2:0] != 3'd0);
         end
         default: begin
            we = r[0];
            re = r[1];
         end
      endcase
      we_i = we;
      re_i = re;
      #1;
      // flags gate the requests of this cycle
      wr_acc = we && !m_full;
      rd_acc = re && !m_empty;
      check_flag({name, " mem_we"}, wr_acc, mem_we);
      check_flag({name, " mem_re"}, rd_acc, mem_re);
      if (we && m_full) n_ovf++;
      if (re && m_empty) n_unf++;
      if (wr_acc && rd_acc) n_both++;
      // state after the next rising edge
      m_wack = wr_acc;
      m_dvld = rd_acc;
      m_ovf  = we && m_full;
      m_unf  = re && m_empty;
      if (wr_acc) begin
         if (m_waddr == addr_t'(`FIFO_DEPTH - 1)) begin
            m_waddr = '0;
            n_wrap++;
         end else begin
            m_waddr = m_waddr + addr_t'(1);
         end
      end
      if (rd_acc) begin
         if (m_raddr == addr_t'(`FIFO_DEPTH - 1)) m_raddr = '0;
         else m_raddr = m_raddr + addr_t'(1);
      end
      // level moves only on a lone write or a lone read
      m_level = m_level + int'(wr_acc) - int'(rd_acc);
      m_full   = (m_level == `FIFO_DEPTH);
      m_afull  = (m_level >= `FIFO_AFULL_VAL);
      m_empty  = (m_level == 0);
      m_aempty = (m_level <= `FIFO_AEMPTY_VAL);
   endtask

   // --------------------
   // timeout
   // --------------------
   always @(posedge pos_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TESTS FAILED");
         $finish;
      end
   end

   initial begin
      // reset values checked while reset is still held
      repeat (RESET_CYCLES) @(negedge pos_clk);
      check_registered("reset");
      check_flag("reset mem_we", 1'b0, mem_we);
      check_flag("reset mem_re", 1'b0, mem_re);
      aresetn = 1'b1;

      repeat (PHASE_CYCLES) run_cycle(PH_WRITE, "write_heavy");
      repeat (PHASE_CYCLES) run_cycle(PH_READ, "read_heavy");
      repeat (PHASE_CYCLES) run_cycle(PH_BAL, "balanced");
      // last operation lands one cycle later
      @(negedge pos_clk);
      check_registered("final");

      if (n_ovf == 0) begin
         other_errs++;
         $display("no write was ever refused while full");
      end
      if (n_unf == 0) begin
         other_errs++;
         $display("no read was ever refused while empty");
      end
      if (n_both == 0) begin
         other_errs++;
         $display("no simultaneous read and write was ever accepted");
      end
      if (n_wrap == 0) begin
         other_errs++;
         $display("the write address never wrapped");
      end

      $display("errors: level %0d, addr %0d, flag %0d, other %0d",
               level_errs, addr_errs, flag_errs, other_errs);
      if (level_errs + addr_errs + flag_errs + other_errs == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

/* logic/fifo_ctrl_top.sv */
// pointer and flag controller for an external single-clock FIFO memory
// stop-on-full and stop-on-empty, active high enables, no prefetch
module fifo_ctrl_top (
   input  logic                   pos_clk,
   input  logic                   aresetn,
   input  logic                   we_i,
   input  logic                   re_i,
   output fifo_ctrl_pkg::addr_t   mem_waddr_o,
   output fifo_ctrl_pkg::addr_t   mem_raddr_o,
   output logic                   mem_we_o,
   output logic                   mem_re_o,
   output fifo_ctrl_pkg::level_t  level_o,
   output logic                   full_o,
   output logic                   afull_o,
   output logic                   empty_o,
   output logic                   aempty_o,
   output logic                   wack_o,
   output logic                   dvld_o,
   output logic                   overflow_o,
   output logic                   underflow_o
);
   import fifo_ctrl_pkg::*;

   fifo_op_e op;
   logic     wr_refused;
   logic     rd_refused;
   level_t   level_next;

   // --------------------
   // decode
   // --------------------
   // full and empty loop back from the result stage
   fifo_req_decode u_decode (
      .we_i         (we_i),
      .re_i         (re_i),
      .full_i       (full_o),
      .empty_i      (empty_o),
      .op_o         (op),
      .wr_refused_o (wr_refused),
      .rd_refused_o (rd_refused)
   );

   // --------------------
   // execute
   // --------------------
   fifo_ptr_execute u_execute (
      .pos_clk      (pos_clk),
      .aresetn      (aresetn),
      .op_i         (op),
      .mem_waddr_o  (mem_waddr_o),
      .mem_raddr_o  (mem_raddr_o),
      .mem_we_o     (mem_we_o),
      .mem_re_o     (mem_re_o),
      .level_o      (level_o),
      .level_next_o (level_next)
   );

   // --------------------
   // result
   // --------------------
   fifo_flag_result u_result (
      .pos_clk      (pos_clk),
      .aresetn      (aresetn),
      .op_i         (op),
      .wr_refused_i (wr_refused),
      .rd_refused_i (rd_refused),
      .level_next_i (level_next),
      .full_o       (full_o),
      .afull_o      (afull_o),
      .empty_o      (empty_o),
      .aempty_o     (aempty_o),
      .wack_o       (wack_o),
      .dvld_o       (dvld_o),
      .overflow_o   (overflow_o),
      .underflow_o  (underflow_o)
   );

endmodule

/* logic/fifo_flag_result.sv */
// registered status flags and single-cycle pulses
// thresholds are plain compares on the next level without hysteresis
`include "fifo_ctrl_cfg.svh"

module fifo_flag_result (
   input  logic                     pos_clk,
   input  logic                     aresetn,
   input  fifo_ctrl_pkg::fifo_op_e  op_i,
   input  logic                     wr_refused_i,
   input  logic                     rd_refused_i,
   input  fifo_ctrl_pkg::level_t    level_next_i,
   output logic                     full_o,
   output logic                     afull_o,
   output logic                     empty_o,
   output logic                     aempty_o,
   output logic                     wack_o,
   output logic                     dvld_o,
   output logic                     overflow_o,
   output logic                     underflow_o
);
   import fifo_ctrl_pkg::*;

   localparam level_t DEPTH_LVL  = level_t'(`FIFO_DEPTH);
   localparam level_t AFULL_LVL  = level_t'(`FIFO_AFULL_VAL);
   localparam level_t AEMPTY_LVL = level_t'(`FIFO_AEMPTY_VAL);

   logic wr_acc;
   logic rd_acc;

   // accepted halves of the opcode
   assign wr_acc = (op_i == FIFO_OP_WRITE) || (op_i == FIFO_OP_BOTH);
   assign rd_acc = (op_i == FIFO_OP_READ)  || (op_i == FIFO_OP_BOTH);

   // --------------------
   // status flags
   // --------------------
   // same edge as the level register so flags and level agree
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         full_o   <= 1'b0;
         afull_o  <= 1'b0;
         // empty after reset
         empty_o  <= 1'b1;
         aempty_o <= 1'b1;
      end else begin
         full_o   <= (level_next_i == DEPTH_LVL);
         afull_o  <= (level_next_i >= AFULL_LVL);
         empty_o  <= (level_next_i == '0);
         aempty_o <= (level_next_i <= AEMPTY_LVL);
      end
   end

   // --------------------
   // pulses
   // --------------------
   // one cycle after the access and high for one cycle per operation
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wack_o      <= 1'b0;
         dvld_o      <= 1'b0;
         overflow_o  <= 1'b0;
         underflow_o <= 1'b0;
      end else begin
         wack_o      <= wr_acc;
         dvld_o      <= rd_acc;
         // a refused request changes nothing else
         overflow_o  <= wr_refused_i;
         underflow_o <= rd_refused_i;
      end
   end

   // a request is never both accepted and refused
   a_acc_refused: assert property (@(posedge pos_clk) disable iff (!aresetn)
      !(wr_acc && wr_refused_i) && !(rd_acc && rd_refused_i))
      else $error("request both accepted and refused");

endmodule

/* logic/fifo_ptr_execute.sv */
// address counters and occupancy counter, one operation per cycle
// strobes are combinational from the opcode, addresses move on the next edge
`include "fifo_ctrl_cfg.svh"

module fifo_ptr_execute (
   input  logic                     pos_clk,
   input  logic                     aresetn,
   input  fifo_ctrl_pkg::fifo_op_e  op_i,
   output fifo_ctrl_pkg::addr_t     mem_waddr_o,
   output fifo_ctrl_pkg::addr_t     mem_raddr_o,
   output logic                     mem_we_o,
   output logic                     mem_re_o,
   output fifo_ctrl_pkg::level_t    level_o,
   output fifo_ctrl_pkg::level_t    level_next_o
);
   import fifo_ctrl_pkg::*;

   localparam addr_t LAST_ADDR = addr_t'(`FIFO_DEPTH - 1);

   // next address, explicit wrap for non power of two depths
   function automatic addr_t wrap_inc(input addr_t addr);
      if (addr == LAST_ADDR) begin
         return '0;
      end
      return addr + addr_t'(1);
   endfunction

   // --------------------
   // memory strobes
   // --------------------
   assign mem_we_o = (op_i == FIFO_OP_WRITE) || (op_i == FIFO_OP_BOTH);
   assign mem_re_o = (op_i == FIFO_OP_READ)  || (op_i == FIFO_OP_BOTH);

   // --------------------
   // address counters
   // --------------------
   // address shown is the one used this cycle
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         mem_waddr_o <= '0;
         mem_raddr_o <= '0;
      end else begin
         if (mem_we_o) begin
            mem_waddr_o <= wrap_inc(mem_waddr_o);
         end
         if (mem_re_o) begin
            mem_raddr_o <= wrap_inc(mem_raddr_o);
         end
      end
   end

   // --------------------
   // occupancy
   // --------------------
   // simultaneous read and write holds the level
   always_comb begin
      case (op_i)
         FIFO_OP_WRITE: level_next_o = level_o + level_t'(1);
         FIFO_OP_READ:  level_next_o = level_o - level_t'(1);
         default:       level_next_o = level_o;
      endcase
   end

   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         level_o <= '0;
      end else begin
         level_o <= level_next_o;
      end
   end

   // decode gating must keep the count in range
   a_level_range: assert property (@(posedge pos_clk) disable iff (!aresetn)
      level_o <= level_t'(`FIFO_DEPTH))
      else $error("level above depth");

endmodule

/* logic/fifo_req_decode.sv */
// request qualification for stop-on-full and stop-on-empty only
// full_i and empty_i must be the registered flags of the same cycle
module fifo_req_decode (
   input  logic                     we_i,
   input  logic                     re_i,
   input  logic                     full_i,
   input  logic                     empty_i,
   output fifo_ctrl_pkg::fifo_op_e  op_o,
   output logic                     wr_refused_o,
   output logic                     rd_refused_o
);
   import fifo_ctrl_pkg::*;

   logic wr_ok;
   logic rd_ok;

   // the only place the flags gate a request
   assign wr_ok = we_i & ~full_i;
   assign rd_ok = re_i & ~empty_i;

   // refused requests become error pulses downstream
   assign wr_refused_o = we_i & full_i;
   assign rd_refused_o = re_i & empty_i;

   // --------------------
   // opcode encode
   // --------------------
   always_comb begin
      case ({rd_ok, wr_ok})
         2'b01:   op_o = FIFO_OP_WRITE;
         2'b10:   op_o = FIFO_OP_READ;
         // both legal only when neither full nor empty
         2'b11:   op_o = FIFO_OP_BOTH;
         default: op_o = FIFO_OP_IDLE;
      endcase
   end

endmodule

/* logic/fifo_ctrl_pkg.sv */
// shared types of the FIFO controller
// widths come from the cfg header, edit them there
`include "fifo_ctrl_cfg.svh"

package fifo_ctrl_pkg;

   // accepted operation of one cycle
   // bit 0 is the write, bit 1 the read
   typedef enum logic [1:0] {
      FIFO_OP_IDLE  = 2'b00,
      FIFO_OP_WRITE = 2'b01,
      FIFO_OP_READ  = 2'b10,
      FIFO_OP_BOTH  = 2'b11
   } fifo_op_e;

   // memory address, 0 to depth-1
   typedef logic [`FIFO_AW-1:0] addr_t;

   // occupancy, 0 to depth inclusive
   typedef logic [`FIFO_CW-1:0] level_t;

endpackage

/* logic/fifo_ctrl_cfg.svh */
// depth, widths and flag thresholds, all fixed at compile time
// FIFO_CW must hold FIFO_DEPTH itself, FIFO_AW must hold FIFO_DEPTH-1
`ifndef FIFO_CTRL_CFG_SVH
`define FIFO_CTRL_CFG_SVH

// --------------------
// memory geometry
// --------------------
// addresses wrap explicitly, so any depth works
`define FIFO_DEPTH 16
`define FIFO_AW 4
// one bit more than the address, full count fits
`define FIFO_CW 5

// --------------------
// status thresholds
// --------------------
// afull at or above, aempty at or below
`define FIFO_AFULL_VAL 14
`define FIFO_AEMPTY_VAL 2

`endif
